//--- build.f
hdl/sha256_pkg.sv
hdl/sha256_bus_regs.sv
hdl/sha256_word_fifo.sv
hdl/sha256_msg_sched.sv
hdl/sha256_engine.sv
hdl/sha256_accel_top.sv
dv/tb_sha256_accel.sv

//--- dv/tb_sha256_accel.sv
module tb_sha256_accel;
  timeunit 1ns;
  timeprecision 1ps;

  // all tests together take well under 1000 cycles
  localparam int MAX_CYCLES = 5000;

  logic                          sha256_clk;
  logic                          bus_rstn;
  logic [sha256_pkg::ADDR_W-1:0] sys_addr;
  sha256_pkg::word_t             sys_wdata;
  sha256_pkg::word_t             sys_rdata;
  logic                          sys_wen;
  logic                          sys_ren;
  logic                          sys_ack;
  logic                          sys_err;
  logic                          x11_act;
  int                            checks;
  int                            errors;
  int                            cycles;
  int                            seed;

  sha256_accel_top i_sha256_accel_top (
    .sha256_clk      (sha256_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr),
    .sys_wdata_i     (sys_wdata),
    .sys_wen_i       (sys_wen),
    .sys_ren_i       (sys_ren),
    .sys_rdata_o     (sys_rdata),
    .sys_ack_o       (sys_ack),
    .sys_err_o       (sys_err),
    .x11_activated_o (x11_act)
  );

  always #10 sha256_clk = ~sha256_clk;  // 20 ns period

  // run limit
  always @(posedge sha256_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a test never finished", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // compare and bus tasks
  task automatic check_word(input string name, input sha256_pkg::word_t exp,
                            input sha256_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_digest(input string name, input sha256_pkg::digest_t exp,
                              input sha256_pkg::digest_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR %s", what);
  endtask

  task automatic bus_write(input logic [sha256_pkg::ADDR_W-1:0] addr,
                           input sha256_pkg::word_t data);
    @(negedge sha256_clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;
    @(negedge sha256_clk);
    sys_wen = 1'b0;                          // ack registered at the edge in between
    if (sys_ack !== 1'b1 || sys_err !== 1'b0)
      report_error($sformatf("write to %h got no clean acknowledge", addr));
  endtask

  task automatic bus_read(input logic [sha256_pkg::ADDR_W-1:0] addr,
                          output sha256_pkg::word_t data);
    @(negedge sha256_clk);
    sys_addr = addr;
    sys_ren  = 1'b1;
    @(negedge sha256_clk);
    sys_ren = 1'b0;
    data    = sys_rdata;
    if (sys_ack !== 1'b1 || sys_err !== 1'b0)
      report_error($sformatf("read of %h got no clean acknowledge", addr));
  endtask

  task automatic read_digest(output sha256_pkg::digest_t d);
    sha256_pkg::word_t             w;
    logic [sha256_pkg::ADDR_W-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = sha256_pkg::REG_SHA_HASH_H0 - 4 * i;  // H0 at the top offset
      bus_read(addr, w);
      d[255 - 32*i -: 32] = w;
    end
  endtask

  task automatic wait_hash_valid();
    sha256_pkg::word_t st;
    for (int n = 0; n < 400; n++) begin
      bus_read(sha256_pkg::REG_SHA_STATUS, st);
      if (st[sha256_pkg::STAT_HASH_VALID])
        return;
    end
    report_error("hash_valid never rose in SHA status");
  endtask

  task automatic push_abc();
    bus_write(sha256_pkg::REG_SHA_PUSH, 32'h61626380);  // "abc" then the 1 bit
    repeat (14) bus_write(sha256_pkg::REG_SHA_PUSH, 32'h0);
    bus_write(sha256_pkg::REG_SHA_PUSH, 32'h00000018);  // 24 bit length
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %-22s %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // ------------------------------
  // directed tests
  task automatic reset_and_version();
    sha256_pkg::word_t r;
    int                e0;
    e0 = errors;
    bus_read(sha256_pkg::REG_CTRL, r);
    check_word("reg_ctrl", 32'h0, r);
    bus_read(sha256_pkg::REG_VERSION, r);
    check_word("reg_version", sha256_pkg::BUILD_DATE, r);
    check_word("x11_activated_o", 32'h0, {31'b0, x11_act});
    bus_write(sha256_pkg::REG_CTRL, 32'h1 << sha256_pkg::CTRL_ENABLE);
    check_word("x11_activated_o", 32'h1, {31'b0, x11_act});
    bus_read(sha256_pkg::REG_STATUS, r);
    check_word("reg_status", 32'h1 << sha256_pkg::STAT_X11_ACT, r);  // sha still off
    bus_write(sha256_pkg::REG_SHA_CTRL, 32'h1 << sha256_pkg::SHA_CTRL_ENABLE);
    bus_read(sha256_pkg::REG_STATUS, r);
    check_word("reg_status", (32'h1 << sha256_pkg::STAT_X11_ACT)
                             | (32'h1 << sha256_pkg::STAT_SHA_ACT), r);
    end_test("reset_version", e0);
  endtask

  task automatic abc_single_block();
    sha256_pkg::digest_t d;
    int                  e0;
    e0 = errors;
    push_abc();
    wait_hash_valid();
    read_digest(d);
    check_digest("digest_abc",
      256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad, d);
    end_test("abc_block", e0);
  endtask

  task automatic two_block_chain();
    sha256_pkg::digest_t d;
    int                  e0;
    e0 = errors;
    for (int i = 0; i < 14; i++)                       // "abcd" "bcde" ... "nopq"
      bus_write(sha256_pkg::REG_SHA_PUSH, 32'h61626364 + i * 32'h01010101);
    bus_write(sha256_pkg::REG_SHA_PUSH, 32'h80000000);
    bus_write(sha256_pkg::REG_SHA_PUSH, 32'h0);
    repeat (15) bus_write(sha256_pkg::REG_SHA_PUSH, 32'h0);  // second block holds only length
    bus_write(sha256_pkg::REG_SHA_PUSH, 32'h000001c0);       // 448 bits
    wait_hash_valid();
    read_digest(d);
    check_digest("digest_448",
      256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1, d);
    end_test("two_block", e0);
  endtask

  task automatic disabled_push_drop();
    sha256_pkg::word_t   r;
    sha256_pkg::digest_t d;
    int                  e0;
    e0 = errors;
    bus_write(sha256_pkg::REG_SHA_CTRL, 32'h0);
    repeat (4) bus_write(sha256_pkg::REG_SHA_PUSH, 32'hdeadbeef);  // all dropped
    bus_read(sha256_pkg::REG_SHA_STATUS, r);
    check_word("sha_status_fifo_empty", 32'h1, {31'b0, r[sha256_pkg::STAT_FIFO_EMPTY]});
    bus_read(sha256_pkg::REG_SHA_FIFO_CNT, r);
    check_word("reg_sha_fifo_cnt", 32'h0, r);
    read_digest(d);
    check_digest("digest_disabled", '0, d);
    end_test("sha_disabled", e0);
  endtask

  task automatic soft_reset_clear();
    sha256_pkg::word_t   r;
    sha256_pkg::digest_t d;
    int                  e0;
    e0 = errors;
    bus_write(sha256_pkg::REG_SHA_CTRL, 32'h1);
    push_abc();                                 // load hash regs before clearing them
    wait_hash_valid();
    read_digest(d);
    check_digest("digest_abc",
      256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad, d);
    bus_write(sha256_pkg::REG_SHA_CTRL, 32'h3);   // enable plus reset pulse
    bus_read(sha256_pkg::REG_SHA_CTRL, r);
    check_word("reg_sha_ctrl", 32'h1, r);         // reset bit self cleared
    read_digest(d);
    check_digest("digest_after_reset", '0, d);
    end_test("soft_reset", e0);
  endtask

  task automatic unmapped_and_busy_fifo();
    sha256_pkg::word_t r;
    int                e0;
    e0 = errors;
    bus_read(20'h00008, r);
    check_word("unmapped_0x008", 32'h0, r);
    bus_read(20'h00200, r);
    check_word("unmapped_0x200", 32'h0, r);
    repeat (16) bus_write(sha256_pkg::REG_SHA_PUSH, $random(seed));  // engine starts rounds
    repeat (3) bus_write(sha256_pkg::REG_SHA_PUSH, $random(seed));   // queued while busy
    bus_read(sha256_pkg::REG_SHA_FIFO_CNT, r);
    checks++;
    if (r == 0 || r > 3) begin
      errors++;
      $display("FAIL reg_sha_fifo_cnt expected 1 to 3 got %h", r);
    end
    end_test("unmapped_and_busy", e0);
  endtask

  // ------------------------------
  initial begin
    seed       = 13;
    sha256_clk = 1'b0;
    bus_rstn   = 1'b0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    checks     = 0;
    errors     = 0;
    cycles     = 0;
    repeat (2) @(posedge sha256_clk);
    @(negedge sha256_clk);
    bus_rstn = 1'b1;
    reset_and_version();
    abc_single_block();
    two_block_chain();
    disabled_push_drop();
    soft_reset_clear();
    unmapped_and_busy_fifo();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- hdl/sha256_accel_top.sv
module sha256_accel_top (
  input  logic                          sha256_clk,
  input  logic                          bus_rstn,
  input  logic [sha256_pkg::ADDR_W-1:0] sys_addr_i,
  input  sha256_pkg::word_t             sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output sha256_pkg::word_t             sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  output logic                          x11_activated_o
);

  logic                  sha_rstn;     // engine side reset
  logic                  push_en;
  sha256_pkg::word_t     push_data;
  logic                  fifo_full, fifo_m1full, fifo_empty;
  sha256_pkg::fifo_cnt_t fifo_cnt;
  logic                  fifo_rd_en, fifo_rd_vld;
  sha256_pkg::word_t     fifo_rd_data;
  logic                  eng_rdy, hash_valid;
  sha256_pkg::digest_t   digest;

  sha256_bus_regs i_bus_regs (
    .sha256_clk      (sha256_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .eng_rdy_i       (eng_rdy),
    .hash_valid_i    (hash_valid),
    .digest_i        (digest),
    .fifo_full_i     (fifo_full),
    .fifo_m1full_i   (fifo_m1full),
    .fifo_empty_i    (fifo_empty),
    .fifo_cnt_i      (fifo_cnt),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o),
    .x11_activated_o (x11_activated_o),
    .sha_rstn_o      (sha_rstn),
    .push_en_o       (push_en),
    .push_data_o     (push_data)
  );

  // ------------------------------
  // message path: bus push -> fifo -> engine
  sha256_word_fifo i_word_fifo (
    .sha256_clk (sha256_clk),
    .rstn_i     (sha_rstn),
    .wr_en_i    (push_en),
    .wr_data_i  (push_data),
    .rd_en_i    (fifo_rd_en),
    .rd_data_o  (fifo_rd_data),
    .rd_vld_o   (fifo_rd_vld),
    .full_o     (fifo_full),
    .m1full_o   (fifo_m1full),
    .empty_o    (fifo_empty),
    .count_o    (fifo_cnt)
  );

  sha256_engine i_engine (
    .sha256_clk     (sha256_clk),
    .rstn_i         (sha_rstn),
    .fifo_empty_i   (fifo_empty),
    .fifo_rd_en_o   (fifo_rd_en),
    .fifo_rd_vld_i  (fifo_rd_vld),
    .fifo_rd_data_i (fifo_rd_data),
    .rdy_o          (eng_rdy),
    .hash_valid_o   (hash_valid),
    .digest_o       (digest)
  );

endmodule

//--- hdl/sha256_bus_regs.sv
module sha256_bus_regs (
  input  logic                            sha256_clk,
  input  logic                            bus_rstn,
  input  logic [sha256_pkg::ADDR_W-1:0]   sys_addr_i,
  input  sha256_pkg::word_t               sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  input  logic                            eng_rdy_i,
  input  logic                            hash_valid_i,
  input  sha256_pkg::digest_t             digest_i,
  input  logic                            fifo_full_i,
  input  logic                            fifo_m1full_i,
  input  logic                            fifo_empty_i,
  input  sha256_pkg::fifo_cnt_t           fifo_cnt_i,
  output sha256_pkg::word_t               sys_rdata_o,
  output logic                            sys_ack_o,
  output logic                            sys_err_o,
  output logic                            x11_activated_o,
  output logic                            sha_rstn_o,
  output logic                            push_en_o,
  output sha256_pkg::word_t               push_data_o
);

  sha256_pkg::word_t             ctrl_q;       // top control
  sha256_pkg::word_t             sha_ctrl_q;   // engine control with one-shot bit 1
  sha256_pkg::word_t             hash_q [8];   // [0] is H7 at the lowest offset
  logic                          hash_valid_d;
  sha256_pkg::word_t             top_status;
  sha256_pkg::word_t             sha_status;
  sha256_pkg::word_t             rd_mux;
  logic [sha256_pkg::ADDR_W-1:0] hash_off;     // byte offset into hash window

  assign x11_activated_o = ctrl_q[sha256_pkg::CTRL_ENABLE];

  // engine side held in reset unless both enables set, and for one cycle per RESET write
  assign sha_rstn_o = x11_activated_o & sha_ctrl_q[sha256_pkg::SHA_CTRL_ENABLE]
                      & ~sha_ctrl_q[sha256_pkg::SHA_CTRL_RESET];

  // ------------------------------
  // register writes
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_en_o  <= 1'b0;
    end else begin
      sha_ctrl_q <= sha_ctrl_q & ~sha256_pkg::SHA_CTRL_ONESHOT_MASK;  // drop one-shots
      push_en_o  <= 1'b0;
      if (sys_wen_i) begin
        case (sys_addr_i)
          sha256_pkg::REG_CTRL:     ctrl_q     <= sys_wdata_i;
          sha256_pkg::REG_SHA_CTRL: sha_ctrl_q <= sys_wdata_i;
          sha256_pkg::REG_SHA_PUSH: push_en_o  <= 1'b1;           // one word into fifo
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge sha256_clk) begin
    if (sys_wen_i && sys_addr_i == sha256_pkg::REG_SHA_PUSH)
      push_data_o <= sys_wdata_i;
  end

  // ------------------------------
  // digest capture on rising hash_valid
  always_ff @(posedge sha256_clk) begin
    if (!sha_rstn_o) begin
      hash_valid_d <= 1'b0;
      for (int i = 0; i < 8; i++)
        hash_q[i] <= '0;
    end else begin
      hash_valid_d <= hash_valid_i;
      if (hash_valid_i && !hash_valid_d) begin
        for (int i = 0; i < 8; i++)
          hash_q[i] <= digest_i[i*sha256_pkg::WORD_W +: sha256_pkg::WORD_W];  // H7 lowest
      end
    end
  end

  // ------------------------------
  // status words and read mux
  always_comb begin
    top_status = '0;
    top_status[sha256_pkg::STAT_X11_ACT] = x11_activated_o;
    top_status[sha256_pkg::STAT_SHA_ACT] = sha_rstn_o;
    sha_status = '0;
    sha_status[sha256_pkg::STAT_RDY]         = eng_rdy_i;
    sha_status[sha256_pkg::STAT_HASH_VALID]  = hash_valid_i;
    sha_status[sha256_pkg::STAT_FIFO_EMPTY]  = fifo_empty_i;
    sha_status[sha256_pkg::STAT_FIFO_M1FULL] = fifo_m1full_i;
    sha_status[sha256_pkg::STAT_FIFO_FULL]   = fifo_full_i;
  end

  always_comb begin
    hash_off = sys_addr_i - sha256_pkg::REG_SHA_HASH_H7;  // wraps large below H7
    rd_mux   = '0;                                        // unmapped reads zero
    case (sys_addr_i)
      sha256_pkg::REG_CTRL:         rd_mux = ctrl_q;
      sha256_pkg::REG_STATUS:       rd_mux = top_status;
      sha256_pkg::REG_VERSION:      rd_mux = sha256_pkg::BUILD_DATE;
      sha256_pkg::REG_SHA_CTRL:     rd_mux = sha_ctrl_q;
      sha256_pkg::REG_SHA_STATUS:   rd_mux = sha_status;
      sha256_pkg::REG_SHA_FIFO_CNT: rd_mux = sha256_pkg::word_t'(fifo_cnt_i);
      default: begin
        if (hash_off < 32 && sys_addr_i[1:0] == 2'b00)
          rd_mux = hash_q[hash_off[4:2]];
      end
    endcase
  end

  // one-cycle acknowledge and err held low
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= sys_ren_i ? rd_mux : '0;
    end
  end

  // a lone strobe gets exactly one ack cycle
  a_ack_single: assert property (@(posedge sha256_clk) disable iff (!bus_rstn)
    (sys_wen_i || sys_ren_i) ##1 !(sys_wen_i || sys_ren_i) |-> sys_ack_o ##1 !sys_ack_o);

endmodule

//--- hdl/sha256_engine.sv
module sha256_engine (
  input  logic                sha256_clk,
  input  logic                rstn_i,
  input  logic                fifo_empty_i,
  output logic                fifo_rd_en_o,
  input  logic                fifo_rd_vld_i,
  input  sha256_pkg::word_t   fifo_rd_data_i,
  output logic                rdy_o,
  output logic                hash_valid_o,
  output sha256_pkg::digest_t digest_o
);

  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_ROUND, S_ADD, S_DONE} state_t;

  state_t              state;
  sha256_pkg::word_t   a, b, c, d, e, f, g, h;   // working variables
  sha256_pkg::digest_t h_q;                      // chaining value
  sha256_pkg::digest_t vars;
  sha256_pkg::word_t   w;
  sha256_pkg::word_t   t1, t2, bs0, bs1, ch, maj;
  logic [4:0]          pop_cnt;                  // words requested this block
  logic [4:0]          rcv_cnt;                  // words received
  logic [5:0]          round;
  logic                last_word;

  assign fifo_rd_en_o = state == S_LOAD && !fifo_empty_i && pop_cnt < sha256_pkg::BLOCK_WORDS;
  assign last_word    = fifo_rd_vld_i && rcv_cnt == sha256_pkg::BLOCK_WORDS - 1;
  assign rdy_o        = state == S_IDLE;
  assign digest_o     = h_q;
  assign vars         = {a, b, c, d, e, f, g, h};  // lines up with H0..H7

  sha256_msg_sched i_msg_sched (
    .sha256_clk  (sha256_clk),
    .rstn_i      (rstn_i),
    .load_i      (state == S_LOAD && fifo_rd_vld_i),
    .load_word_i (fifo_rd_data_i),
    .shift_i     (state == S_ROUND),
    .w_o         (w)
  );

  // ------------------------------
  // round function
  always_comb begin
    bs1 = sha256_pkg::rotr(e, 6) ^ sha256_pkg::rotr(e, 11) ^ sha256_pkg::rotr(e, 25);
    ch  = (e & f) ^ (~e & g);
    t1  = h + bs1 + ch + sha256_pkg::SHA_K[round] + w;
    bs0 = sha256_pkg::rotr(a, 2) ^ sha256_pkg::rotr(a, 13) ^ sha256_pkg::rotr(a, 22);
    maj = (a & b) ^ (a & c) ^ (b & c);
    t2  = bs0 + maj;
  end

  // ------------------------------
  // control FSM
  always_ff @(posedge sha256_clk) begin
    if (!rstn_i) begin
      state        <= S_IDLE;
      hash_valid_o <= 1'b0;
      pop_cnt      <= '0;
      rcv_cnt      <= '0;
      round        <= '0;
    end else begin
      case (state)
        S_IDLE: if (!fifo_empty_i) begin          // new message
          state        <= S_LOAD;
          hash_valid_o <= 1'b0;
          pop_cnt      <= '0;
          rcv_cnt      <= '0;
        end
        S_LOAD: begin                              // stalls while fifo runs dry
          if (fifo_rd_en_o)
            pop_cnt <= pop_cnt + 1'b1;
          if (fifo_rd_vld_i)
            rcv_cnt <= rcv_cnt + 1'b1;
          if (last_word) begin
            state <= S_ROUND;
            round <= '0;
          end
        end
        S_ROUND: begin
          round <= round + 1'b1;
          if (round == sha256_pkg::SHA_ROUNDS - 1)
            state <= S_ADD;
        end
        S_ADD: begin                               // block boundary where empty fifo ends message
          pop_cnt <= '0;
          rcv_cnt <= '0;
          state   <= fifo_empty_i ? S_DONE : S_LOAD;
        end
        S_DONE: begin
          hash_valid_o <= 1'b1;
          state        <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge sha256_clk) begin
    case (state)
      S_IDLE: if (!fifo_empty_i) h_q <= sha256_pkg::SHA_H_INIT;
      S_LOAD: if (last_word) {a, b, c, d, e, f, g, h} <= h_q;
      S_ROUND: begin
        h <= g;
        g <= f;
        f <= e;
        e <= d + t1;
        d <= c;
        c <= b;
        b <= a;
        a <= t1 + t2;
      end
      S_ADD: begin
        for (int i = 0; i < 8; i++)
          h_q[i*32 +: 32] <= h_q[i*32 +: 32] + vars[i*32 +: 32];
      end
      default: ;
    endcase
  end

  // digest flag only stands while the FSM idles
  a_idle_flag: assert property (@(posedge sha256_clk) disable iff (!rstn_i)
    hash_valid_o |-> rdy_o);

endmodule

//--- hdl/sha256_msg_sched.sv
module sha256_msg_sched (
  input  logic              sha256_clk,
  input  logic              rstn_i,
  input  logic              load_i,       // block word arriving
  input  sha256_pkg::word_t load_word_i,
  input  logic              shift_i,      // one round done
  output sha256_pkg::word_t w_o
);

  sha256_pkg::word_t win [sha256_pkg::BLOCK_WORDS];  // win[0] is W of this round
  sha256_pkg::word_t ssig0;
  sha256_pkg::word_t ssig1;
  sha256_pkg::word_t nxt;

  // W[t+16] = s1(W[t+14]) + W[t+9] + s0(W[t+1]) + W[t]
  always_comb begin
    ssig0 = sha256_pkg::rotr(win[1], 7) ^ sha256_pkg::rotr(win[1], 18) ^ (win[1] >> 3);
    ssig1 = sha256_pkg::rotr(win[14], 17) ^ sha256_pkg::rotr(win[14], 19) ^ (win[14] >> 10);
    nxt   = load_i ? load_word_i : ssig1 + win[9] + ssig0 + win[0];
  end

  // load and rounds both slide the window by one word
  always_ff @(posedge sha256_clk) begin
    if (!rstn_i) begin
      for (int i = 0; i < sha256_pkg::BLOCK_WORDS; i++)
        win[i] <= '0;
    end else if (load_i || shift_i) begin
      for (int i = 0; i < sha256_pkg::BLOCK_WORDS - 1; i++)
        win[i] <= win[i+1];
      win[sha256_pkg::BLOCK_WORDS-1] <= nxt;
    end
  end

  assign w_o = win[0];

endmodule

//--- hdl/sha256_pkg.sv
package sha256_pkg;

  // ------------------------------
  // widths and types
  localparam int WORD_W     = 32;           // bus and message word
  localparam int ADDR_W     = 20;           // decoded address bits
  localparam int FIFO_DEPTH = 32;           // words
  localparam int FIFO_CNT_W = 6;            // holds 0 .. FIFO_DEPTH
  localparam int SHA_ROUNDS = 64;
  localparam int BLOCK_WORDS = 16;          // 512 bit block

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [8*WORD_W-1:0]   digest_t;  // H0 in the top word
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  // ------------------------------
  // register map
  localparam logic [ADDR_W-1:0] REG_CTRL         = 20'h00000;
  localparam logic [ADDR_W-1:0] REG_STATUS       = 20'h00004;
  localparam logic [ADDR_W-1:0] REG_VERSION      = 20'h0000C;
  localparam logic [ADDR_W-1:0] REG_SHA_CTRL     = 20'h00100;
  localparam logic [ADDR_W-1:0] REG_SHA_STATUS   = 20'h00104;
  localparam logic [ADDR_W-1:0] REG_SHA_PUSH     = 20'h0010C;  // write only
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H7  = 20'h00110;  // least significant word
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H6  = 20'h00114;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H5  = 20'h00118;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H4  = 20'h0011C;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H3  = 20'h00120;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H2  = 20'h00124;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H1  = 20'h00128;
  localparam logic [ADDR_W-1:0] REG_SHA_HASH_H0  = 20'h0012C;  // most significant word
  localparam logic [ADDR_W-1:0] REG_SHA_FIFO_CNT = 20'h00130;

  // control and status bits
  localparam int CTRL_ENABLE     = 0;
  localparam int SHA_CTRL_ENABLE = 0;
  localparam int SHA_CTRL_RESET  = 1;       // self clearing
  localparam word_t SHA_CTRL_ONESHOT_MASK = 32'h0000_0002;

  localparam int STAT_RDY         = 0;
  localparam int STAT_HASH_VALID  = 1;
  localparam int STAT_FIFO_EMPTY  = 4;
  localparam int STAT_FIFO_M1FULL = 5;
  localparam int STAT_FIFO_FULL   = 6;
  localparam int STAT_X11_ACT     = 0;      // top status word
  localparam int STAT_SHA_ACT     = 4;

  localparam word_t BUILD_DATE = 32'h26011001;  // yymmddss

  // ------------------------------
  // sha-256 constants, index 0 first
  localparam logic [0:SHA_ROUNDS-1][WORD_W-1:0] SHA_K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  localparam digest_t SHA_H_INIT = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // rotate right, used by schedule and compression
  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << (WORD_W - n));
  endfunction

endpackage

//--- hdl/sha256_word_fifo.sv
module sha256_word_fifo (
  input  logic                  sha256_clk,
  input  logic                  rstn_i,
  input  logic                  wr_en_i,
  input  sha256_pkg::word_t     wr_data_i,
  input  logic                  rd_en_i,
  output sha256_pkg::word_t     rd_data_o,
  output logic                  rd_vld_o,
  output logic                  full_o,
  output logic                  m1full_o,
  output logic                  empty_o,
  output sha256_pkg::fifo_cnt_t count_o
);

  sha256_pkg::word_t                  mem [sha256_pkg::FIFO_DEPTH];
  logic [sha256_pkg::FIFO_CNT_W-2:0]  wr_ptr;   // wraps at FIFO_DEPTH
  logic [sha256_pkg::FIFO_CNT_W-2:0]  rd_ptr;
  logic                               do_wr;
  logic                               do_rd;

  assign do_wr    = wr_en_i & ~full_o;          // push while full is lost
  assign do_rd    = rd_en_i & ~empty_o;
  assign full_o   = count_o == sha256_pkg::FIFO_DEPTH;
  assign m1full_o = count_o >= sha256_pkg::FIFO_DEPTH - 1;  // room for one more
  assign empty_o  = count_o == '0;

  // ------------------------------
  // pointers and fill level
  always_ff @(posedge sha256_clk) begin
    if (!rstn_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_o  <= '0;
      rd_vld_o <= 1'b0;
    end else begin
      rd_vld_o <= do_rd;                        // data one cycle after pop
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: ;
      endcase
    end
  end

  // storage and registered read port
  always_ff @(posedge sha256_clk) begin
    if (do_wr)
      mem[wr_ptr] <= wr_data_i;
    if (do_rd)
      rd_data_o <= mem[rd_ptr];
  end

  // engine only pops what it saw as available
  a_no_pop_empty: assert property (@(posedge sha256_clk) disable iff (!rstn_i)
    rd_en_i |-> !empty_o);

endmodule
